//--- proc.f
+incdir+verif
src/procPkg.sv
src/regFile.sv
src/fetch.sv
src/decode.sv
src/execution.sv
src/memory.sv
src/proc.sv
verif/procTb.sv

//--- src/decode.sv
/* Control decode for the subset; any other opcode sets err and halts
   err stays high until reset
   Register writes and stores are blocked in reset and once halted */
module decode import procPkg::*; (
   input  logic     clk,
   input  logic     rstN,
   input  instrT    instr,
   input  regWbT    wb,
   input  logic     halted,
   output ctrlT     ctrl,
   output operandsT operands,
   output logic     haltReq,
   output logic     err
);

   logic        illegal;
   logic [15:0] imm;

   regFile regs (
      .clk    (clk),
      .rdAddr1(instr.rFmt.rs),
      .rdAddr2(instr.rFmt.rt),   // Same bits as iFmt rd, the ST data
      .rdData1(operands.rdData1),
      .rdData2(operands.rdData2),
      .wb     (wb)
   );

   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = ALU_PASSB;
      ctrl.wbSrc = WB_ALU;
      illegal    = 1'b0;
      imm        = {{11{instr.iFmt.imm[4]}}, instr.iFmt.imm};

      case (instr.rFmt.opcode)
         OP_RALU: begin
            ctrl.regWr = 1'b1;
            ctrl.wrReg = instr.rFmt.rd;
            case (instr.rFmt.func)
               FN_ADD:  ctrl.aluOp = ALU_ADD;
               FN_SUB:  ctrl.aluOp = ALU_SUB;
               FN_XOR:  ctrl.aluOp = ALU_XOR;
               default: ctrl.aluOp = ALU_AND;
            endcase
         end
         OP_SEQ, OP_SLT: begin
            ctrl.setKind = (instr.rFmt.opcode == OP_SEQ) ? SET_EQ : SET_LT;
            ctrl.wbSrc   = WB_SET;
            ctrl.regWr   = 1'b1;
            ctrl.wrReg   = instr.rFmt.rd;
         end
         OP_ADDI, OP_LD: begin
            ctrl.aluOp  = ALU_ADD;   // rs + imm
            ctrl.useImm = 1'b1;
            ctrl.regWr  = 1'b1;
            ctrl.wrReg  = instr.iFmt.rd;
            if (instr.iFmt.opcode == OP_LD) begin
               ctrl.memEn = 1'b1;
               ctrl.wbSrc = WB_MEM;
            end
         end
         OP_ST: begin
            ctrl.aluOp  = ALU_ADD;
            ctrl.useImm = 1'b1;
            ctrl.memEn  = 1'b1;
            ctrl.memWr  = 1'b1;
         end
         OP_LI: begin
            imm        = {{8{instr.bFmt.imm[7]}}, instr.bFmt.imm};
            ctrl.wbSrc = WB_IMM;
            ctrl.regWr = 1'b1;
            ctrl.wrReg = instr.bFmt.rs;
         end
         OP_BEQZ, OP_BNEZ: begin
            imm                = {{8{instr.bFmt.imm[7]}}, instr.bFmt.imm};
            ctrl.branchZero    = (instr.bFmt.opcode == OP_BEQZ);
            ctrl.branchNonZero = (instr.bFmt.opcode == OP_BNEZ);
         end
         OP_J: begin
            imm       = {{5{instr.jFmt.imm[10]}}, instr.jFmt.imm};
            ctrl.jump = 1'b1;
         end
         OP_HALT: ctrl.halt = 1'b1;
         default: begin
            illegal   = 1'b1;
            ctrl.halt = 1'b1;   // Trap, pc holds here
         end
      endcase

      if (halted || !rstN) begin
         ctrl.regWr = 1'b0;   // No writeback strobe in reset
         ctrl.memWr = 1'b0;
      end
   end

   assign operands.imm = imm;
   assign haltReq      = ctrl.halt;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         err <= 1'b0;
      end else if (illegal && !halted) begin
         err <= 1'b1;
      end
   end

endmodule

//--- src/execution.sv
/* ALU, set compare and next-PC logic, all combinational
   Branch and jump targets are relative to pc + 2
   Compares are signed; branches test read data 1 (rs) */
module execution import procPkg::*; (
   input  ctrlT        ctrl,
   input  operandsT    operands,
   input  logic [15:0] pc,
   input  logic [15:0] pcPlusTwo,
   output logic [15:0] aluOut,
   output logic [15:0] setValue,
   output logic [15:0] nextPc
);

   logic [15:0] opA;
   logic [15:0] opB;
   logic        isZero;
   logic        taken;
   logic        setBit;

   assign opA = operands.rdData1;
   assign opB = ctrl.useImm ? operands.imm : operands.rdData2;

   always_comb begin
      case (ctrl.aluOp)
         ALU_ADD: aluOut = opA + opB;   // Also the LD/ST address
         ALU_SUB: aluOut = opA - opB;
         ALU_AND: aluOut = opA & opB;
         ALU_XOR: aluOut = opA ^ opB;
         default: aluOut = opB;
      endcase
   end

   // Set compare always uses both registers, never the immediate
   always_comb begin
      case (ctrl.setKind)
         SET_EQ:  setBit = (operands.rdData1 == operands.rdData2);
         SET_LT:  setBit = ($signed(operands.rdData1) < $signed(operands.rdData2));
         default: setBit = 1'b0;
      endcase
   end

   assign setValue = {15'd0, setBit};

   assign isZero = (opA == 16'd0);

   always_comb begin
      taken = ctrl.jump;
      if (ctrl.branchZero && isZero) begin
         taken = 1'b1;
      end
      if (ctrl.branchNonZero && !isZero) begin
         taken = 1'b1;
      end
   end

   always_comb begin
      if (ctrl.halt) begin
         nextPc = pc;   // Hold on HALT or trap
      end else if (taken) begin
         nextPc = pcPlusTwo + operands.imm;
      end else begin
         nextPc = pcPlusTwo;
      end
   end

endmodule

//--- src/fetch.sv
/* Instruction memory has no reset; load it with progWr while rstN is low
   IMEM_WORDS must be a power of two, pc bit 0 is not used for addressing
   Once halted, pc holds until the next reset */
module fetch import procPkg::*; #(
   parameter int IMEM_WORDS = IMEM_WORDS_DEF
) (
   input  logic        clk,
   input  logic        rstN,
   input  progWrT      progWr,
   input  logic [15:0] nextPc,
   input  logic        haltReq,
   output instrT       instr,
   output logic [15:0] pc,
   output logic [15:0] pcPlusTwo,
   output logic        halted
);

   localparam int AW = $clog2(IMEM_WORDS);

   instrT imem [IMEM_WORDS];

   // Program load port
   always_ff @(posedge clk) begin
      if (progWr.strobe) begin
         imem[progWr.addr[AW-1:0]] <= progWr.word;
      end
   end

   assign instr     = imem[pc[AW:1]];   // Word address wraps at IMEM_WORDS
   assign pcPlusTwo = pc + 16'd2;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         if (!halted) begin
            pc <= nextPc;
         end
         if (haltReq) begin
            halted <= 1'b1;   // Sticky until reset
         end
      end
   end

endmodule

//--- src/memory.sv
/* Data memory plus the writeback result select
   Word addressed by the ALU result, wrapped at DMEM_WORDS (power of two)
   No reset on the array; a load from an unwritten word returns unknown data */
module memory import procPkg::*; #(
   parameter int DMEM_WORDS = DMEM_WORDS_DEF
) (
   input  logic        clk,
   input  ctrlT        ctrl,
   input  operandsT    operands,
   input  logic [15:0] aluOut,
   input  logic [15:0] setValue,
   input  logic [15:0] pc,
   output regWbT       wbOut
);

   localparam int AW = $clog2(DMEM_WORDS);

   logic [15:0] dmem [DMEM_WORDS];
   logic [15:0] readData;
   logic [AW-1:0] addr;

   assign addr = aluOut[AW-1:0];

   always_ff @(posedge clk) begin
      if (ctrl.memEn && ctrl.memWr) begin
         dmem[addr] <= operands.rdData2;   // rt field holds the ST data reg
      end
   end

   assign readData = dmem[addr];

   // Writeback select
   always_comb begin
      wbOut.strobe = ctrl.regWr;
      wbOut.pc     = pc;
      wbOut.regNum = ctrl.wrReg;
      case (ctrl.wbSrc)
         WB_MEM:  wbOut.data = readData;
         WB_IMM:  wbOut.data = operands.imm;
         WB_SET:  wbOut.data = setValue;
         default: wbOut.data = aluOut;
      endcase
   end

endmodule

//--- src/proc.sv
/* Single-cycle 16-bit processor, one instruction per clock after reset
   Load the program with progWr while rstN is low
   wbOut reports every register write; err marks an illegal opcode */
module proc import procPkg::*; #(
   parameter int IMEM_WORDS = IMEM_WORDS_DEF,
   parameter int DMEM_WORDS = DMEM_WORDS_DEF
) (
   input  logic   clk,
   input  logic   rstN,
   input  progWrT progWr,
   output regWbT  wbOut,
   output logic   halted,
   output logic   err
);

   instrT       instr;
   logic [15:0] pc;
   logic [15:0] pcPlusTwo;
   logic [15:0] nextPc;
   logic        haltReq;
   ctrlT        ctrl;
   operandsT    operands;
   logic [15:0] aluOut;
   logic [15:0] setValue;

   fetch #(.IMEM_WORDS(IMEM_WORDS)) fetch0 (
      .clk      (clk),
      .rstN     (rstN),
      .progWr   (progWr),
      .nextPc   (nextPc),
      .haltReq  (haltReq),
      .instr    (instr),
      .pc       (pc),
      .pcPlusTwo(pcPlusTwo),
      .halted   (halted)
   );

   decode decode0 (
      .clk     (clk),
      .rstN    (rstN),
      .instr   (instr),
      .wb      (wbOut),     // Register write comes back from memory
      .halted  (halted),
      .ctrl    (ctrl),
      .operands(operands),
      .haltReq (haltReq),
      .err     (err)
   );

   execution exec0 (
      .ctrl     (ctrl),
      .operands (operands),
      .pc       (pc),
      .pcPlusTwo(pcPlusTwo),
      .aluOut   (aluOut),
      .setValue (setValue),
      .nextPc   (nextPc)
   );

   memory #(.DMEM_WORDS(DMEM_WORDS)) memory0 (
      .clk     (clk),
      .ctrl    (ctrl),
      .operands(operands),
      .aluOut  (aluOut),
      .setValue(setValue),
      .pc      (pc),
      .wbOut   (wbOut)
   );

endmodule

//--- src/procPkg.sv
/* Shared types for the 16-bit single-cycle processor
   Opcodes outside opcodeT are illegal and trap on err
   Memory sizes here are defaults only; proc passes the real values down */
package procPkg;

   parameter int IMEM_WORDS_DEF = 256;
   parameter int DMEM_WORDS_DEF = 256;

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LI   = 5'b11000,
      OP_RALU = 5'b11011,   // ADD, SUB, XOR, AND by func
      OP_SEQ  = 5'b11100,
      OP_SLT  = 5'b11101
   } opcodeT;

   // R-format function field
   typedef enum logic [1:0] {
      FN_ADD = 2'b00,
      FN_SUB = 2'b01,   // rs - rt
      FN_XOR = 2'b10,
      FN_AND = 2'b11
   } funcT;

   // One instruction word, four ways to read it
   typedef union packed {
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         funcT       func;
      } rFmt;
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rd;    // Store data source for ST
         logic [4:0] imm;
      } iFmt;
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;    // LI destination, branch test register
         logic [7:0] imm;
      } bFmt;
      struct packed {
         opcodeT      opcode;
         logic [10:0] imm;
      } jFmt;
   } instrT;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_PASSB} aluOpT;
   typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_IMM, WB_SET} wbSrcT;
   typedef enum logic [1:0] {SET_NONE, SET_EQ, SET_LT} setKindT;

   typedef struct packed {
      aluOpT      aluOp;
      logic       useImm;       // Operand B from immediate
      logic       memEn;
      logic       memWr;
      logic       branchZero;
      logic       branchNonZero;
      logic       jump;
      setKindT    setKind;
      wbSrcT      wbSrc;
      logic       regWr;
      logic [2:0] wrReg;
      logic       halt;         // HALT or illegal opcode
   } ctrlT;

   typedef struct packed {
      logic [15:0] rdData1;
      logic [15:0] rdData2;
      logic [15:0] imm;         // Sign-extended for the format
   } operandsT;

   typedef struct packed {
      logic        strobe;
      logic [15:0] addr;        // Word address
      instrT       word;
   } progWrT;

   typedef struct packed {
      logic        strobe;
      logic [15:0] pc;
      logic [2:0]  regNum;
      logic [15:0] data;
   } regWbT;

endpackage

//--- src/regFile.sv
/* Eight general registers, r0 is not hardwired
   No reset, contents are unknown until written
   Reads are combinational and return the old value during a write cycle */
module regFile import procPkg::*; (
   input  logic        clk,
   input  logic [2:0]  rdAddr1,
   input  logic [2:0]  rdAddr2,
   output logic [15:0] rdData1,
   output logic [15:0] rdData2,
   input  regWbT       wb
);

   logic [15:0] regs [8];

   // Write at the edge that ends the instruction
   always_ff @(posedge clk) begin
      if (wb.strobe) begin
         regs[wb.regNum] <= wb.data;
      end
   end

   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

endmodule

//--- verif/procTests.svh
/* Directed tests, included inside procTb
   Every program starts with LI at word 0 and ends in HALT or a trap */

   task automatic arithmeticTest();
      logic [7:0] a;
      logic [7:0] b;
      logic [4:0] c;
      repeat (3) begin
         a = 8'($random(seed));
         b = 8'($random(seed));
         c = 5'($random(seed));
         prog.push_back(bWord(OP_LI, 3'd1, a));
         prog.push_back(bWord(OP_LI, 3'd2, b));
         prog.push_back(rWord(OP_RALU, 3'd1, 3'd2, 3'd3, FN_ADD));
         prog.push_back(rWord(OP_RALU, 3'd1, 3'd2, 3'd4, FN_SUB));
         prog.push_back(rWord(OP_RALU, 3'd3, 3'd4, 3'd5, FN_AND));
         prog.push_back(rWord(OP_RALU, 3'd1, 3'd3, 3'd6, FN_XOR));
         prog.push_back(iWord(OP_ADDI, 3'd6, 3'd7, c));
         prog.push_back(rWord(OP_RALU, 3'd7, 3'd5, 3'd0, FN_ADD));   // r0 is writable
         prog.push_back(jWord(OP_HALT, 11'd0));
         runProgram(2, 1'b0);
      end
      finishTest("arithmetic");
   endtask

   task automatic memoryTest();
      prog.push_back(bWord(OP_LI, 3'd1, 8'($random(seed))));
      prog.push_back(bWord(OP_LI, 3'd2, 8'($random(seed))));
      prog.push_back(bWord(OP_LI, 3'd3, 8'h80 | 8'($random(seed))));   // Negative word
      prog.push_back(iWord(OP_ST, 3'd1, 3'd2, 5'd3));
      prog.push_back(iWord(OP_ST, 3'd1, 3'd3, 5'h1c));   // Offset -4
      prog.push_back(iWord(OP_ST, 3'd1, 3'd1, 5'd15));
      prog.push_back(iWord(OP_LD, 3'd1, 3'd4, 5'h1c));
      prog.push_back(iWord(OP_LD, 3'd1, 3'd5, 5'd3));
      prog.push_back(iWord(OP_LD, 3'd1, 3'd6, 5'd15));
      prog.push_back(jWord(OP_HALT, 11'd0));
      runProgram(2, 1'b0);
      finishTest("memory");
   endtask

   task automatic controlFlowTest();
      prog.push_back(bWord(OP_LI, 3'd1, 8'd0));
      prog.push_back(bWord(OP_LI, 3'd2, 8'd5));
      prog.push_back(bWord(OP_BEQZ, 3'd1, 8'd2));   // Taken, skips word 3
      prog.push_back(bWord(OP_LI, 3'd3, 8'd99));
      prog.push_back(bWord(OP_BNEZ, 3'd1, 8'd2));   // Not taken
      prog.push_back(bWord(OP_LI, 3'd4, 8'd7));
      prog.push_back(bWord(OP_BEQZ, 3'd2, 8'd2));   // Not taken
      prog.push_back(bWord(OP_BNEZ, 3'd2, 8'd2));   // Taken, skips word 8
      prog.push_back(bWord(OP_LI, 3'd5, 8'd1));
      prog.push_back(jWord(OP_J, 11'd4));           // Forward to word 12
      prog.push_back(jWord(OP_HALT, 11'd0));
      prog.push_back(bWord(OP_LI, 3'd6, 8'd3));
      prog.push_back(bWord(OP_LI, 3'd7, 8'd9));
      prog.push_back(jWord(OP_J, 11'h7f8));         // Back to word 10
      runProgram(2, 1'b0);
      finishTest("controlFlow");
   endtask

   task automatic setCompareTest();
      logic [7:0] a;
      logic [7:0] b;
      for (int i = 0; i < 4; i++) begin
         a = 8'($random(seed));
         b = (i == 0) ? a : 8'($random(seed));   // First pair equal
         if (i == 1) begin
            a = a | 8'h80;   // Negative against positive
            b = b & 8'h7f;
         end
         prog.push_back(bWord(OP_LI, 3'd1, a));
         prog.push_back(bWord(OP_LI, 3'd2, b));
         prog.push_back(rWord(OP_SEQ, 3'd1, 3'd2, 3'd3, FN_ADD));
         prog.push_back(rWord(OP_SLT, 3'd1, 3'd2, 3'd4, FN_ADD));
         prog.push_back(rWord(OP_SLT, 3'd2, 3'd1, 3'd5, FN_ADD));
         prog.push_back(rWord(OP_SEQ, 3'd2, 3'd2, 3'd6, FN_ADD));
         prog.push_back(jWord(OP_HALT, 11'd0));
         runProgram(2, 1'b0);
      end
      finishTest("setCompare");
   endtask

   task automatic haltTest();
      prog.push_back(bWord(OP_LI, 3'd1, 8'd5));
      prog.push_back(jWord(OP_HALT, 11'd0));
      prog.push_back(bWord(OP_LI, 3'd2, 8'd6));   // Never reached
      runProgram(20, 1'b0);
      finishTest("halt");
   endtask

   task automatic illegalOpcodeTest();
      prog.push_back(bWord(OP_LI, 3'd1, 8'd1));
      prog.push_back(jWord(opcodeT'(5'b11111), 11'd0));
      prog.push_back(bWord(OP_LI, 3'd2, 8'd2));
      prog.push_back(jWord(OP_HALT, 11'd0));
      runProgram(4, 1'b1);
      rstN = 1'b0;   // Flags clear while reset is held
      @(posedge clk);
      #1;
      checkFlag("halted", 1'b0, halted);
      checkFlag("err", 1'b0, err);
      finishTest("illegalOpcode");
   endtask

//--- verif/procTb.sv
/* Directed testbench for proc with an instruction-level model of the subset
   Registers and data memory have no reset, so every program writes before it reads
   Programs are loaded while rstN is low; inputs change 1 unit after the rising edge */
module procTb import procPkg::*; ();

   localparam int PERIOD     = 8;
   localparam int RST_CYCLES = 10;
   localparam int PROG_WORDS = 86;   // All test programs together
   localparam int RUNS       = 11;
   localparam int IDLE       = 50;   // Post-halt watch cycles over all runs
   localparam int WATCH_TIME = 2 * (PROG_WORDS + RUNS * RST_CYCLES + IDLE) * PERIOD;

   logic        clk;
   logic        rstN;
   progWrT      progWr;
   regWbT       wbOut;
   logic        halted;
   logic        err;
   int          seed = 32'hc0cf_2f6a;
   int          errors;
   int          lastErrors;
   int          testsRun;
   int          testsFailed;
   instrT       prog [$];
   regWbT       expWb [$];       // Writebacks the model predicts
   logic [15:0] mRegs [8];
   logic [15:0] mMem [256];

   proc uut (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCH_TIME);
      $display("Watchdog expired at %0t, the tests did not complete", $time);
      $display("TB FAILED");
      $finish;
   end

   // Instruction assembly through the union views
   function automatic instrT rWord(opcodeT op, logic [2:0] rs, logic [2:0] rt,
                                   logic [2:0] rd, funcT fn);
      instrT w;
      w.rFmt.opcode = op;
      w.rFmt.rs     = rs;
      w.rFmt.rt     = rt;
      w.rFmt.rd     = rd;
      w.rFmt.func   = fn;
      return w;
   endfunction

   function automatic instrT iWord(opcodeT op, logic [2:0] rs, logic [2:0] rd, logic [4:0] imm);
      instrT w;
      w.iFmt.opcode = op;
      w.iFmt.rs     = rs;
      w.iFmt.rd     = rd;
      w.iFmt.imm    = imm;
      return w;
   endfunction

   function automatic instrT bWord(opcodeT op, logic [2:0] rs, logic [7:0] imm);
      instrT w;
      w.bFmt.opcode = op;
      w.bFmt.rs     = rs;
      w.bFmt.imm    = imm;
      return w;
   endfunction

   function automatic instrT jWord(opcodeT op, logic [10:0] imm);
      instrT w;
      w.jFmt.opcode = op;
      w.jFmt.imm    = imm;
      return w;
   endfunction

   task automatic modelWrite(logic [15:0] pc, logic [2:0] rd, logic [15:0] data);
      mRegs[rd] = data;
      expWb.push_back({1'b1, pc, rd, data});
   endtask

   // Runs prog on the ISA model until HALT or an illegal opcode
   task automatic modelRun();
      logic [15:0] pc;
      logic [15:0] nextPc;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] immI;
      logic [15:0] immB;
      logic [7:0]  addr;
      instrT       w;
      bit          done;
      expWb.delete();
      pc   = '0;
      done = 1'b0;
      for (int step = 0; step < 200 && !done; step++) begin
         w      = prog[pc[15:1]];
         a      = mRegs[w.rFmt.rs];
         b      = mRegs[w.rFmt.rt];
         immI   = {{11{w.iFmt.imm[4]}}, w.iFmt.imm};
         immB   = {{8{w.bFmt.imm[7]}}, w.bFmt.imm};
         addr   = 8'(a + immI);
         nextPc = pc + 16'd2;
         case (w.rFmt.opcode)
            OP_RALU: begin
               case (w.rFmt.func)
                  FN_ADD:  modelWrite(pc, w.rFmt.rd, a + b);
                  FN_SUB:  modelWrite(pc, w.rFmt.rd, a - b);
                  FN_XOR:  modelWrite(pc, w.rFmt.rd, a ^ b);
                  default: modelWrite(pc, w.rFmt.rd, a & b);
               endcase
            end
            OP_SEQ:  modelWrite(pc, w.rFmt.rd, {15'd0, a == b});
            OP_SLT:  modelWrite(pc, w.rFmt.rd, {15'd0, $signed(a) < $signed(b)});
            OP_ADDI: modelWrite(pc, w.iFmt.rd, a + immI);
            OP_LD:   modelWrite(pc, w.iFmt.rd, mMem[addr]);
            OP_ST:   mMem[addr] = mRegs[w.iFmt.rd];
            OP_LI:   modelWrite(pc, w.bFmt.rs, immB);
            OP_BEQZ: if (a == 16'd0) nextPc = nextPc + immB;
            OP_BNEZ: if (a != 16'd0) nextPc = nextPc + immB;
            OP_J:    nextPc = nextPc + {{5{w.jFmt.imm[10]}}, w.jFmt.imm};
            OP_HALT: done = 1'b1;
            default: done = 1'b1;   // Illegal opcode traps
         endcase
         pc = nextPc;
      end
   endtask

   task automatic checkWb(string name, regWbT exp, regWbT act);
      if (act !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s expected pc=%h r%0d=%h, got pc=%h r%0d=%h", $time,
                  name, exp.pc, exp.regNum, exp.data, act.pc, act.regNum, act.data);
      end
   endtask

   task automatic checkFlag(string name, logic exp, logic act);
      if (act !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   // Reset for at least RST_CYCLES, one program word per cycle
   task automatic loadProgram();
      rstN = 1'b0;
      for (int i = 0; i < RST_CYCLES || i < prog.size(); i++) begin
         progWr = '0;
         if (i < prog.size()) begin
            progWr = {1'b1, 16'(i), prog[i]};
         end
         @(posedge clk);
         #1;
         checkFlag("wbOut.strobe", 1'b0, wbOut.strobe);   // Quiet while in reset
         checkFlag("halted", 1'b0, halted);
         checkFlag("err", 1'b0, err);
      end
      progWr = '0;
      rstN   = 1'b1;
   endtask

   task automatic runProgram(int idleCycles, logic expErr);
      int cycles;
      modelRun();
      loadProgram();
      cycles = 0;
      while (!halted && cycles < 2 * prog.size() + 10) begin
         @(negedge clk);
         if (wbOut.strobe && expWb.size() == 0) begin
            errors++;
            $display("Error at %0t: unexpected writeback from pc %h", $time, wbOut.pc);
         end else if (wbOut.strobe) begin
            checkWb("wbOut", expWb.pop_front(), wbOut);
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!halted) begin
         errors++;
         $display("Error at %0t: processor did not halt within %0d cycles", $time, cycles);
      end
      repeat (idleCycles) begin
         @(negedge clk);
         if (wbOut.strobe) begin
            errors++;
            $display("Error at %0t: writeback to r%0d after halt", $time, wbOut.regNum);
         end
         @(posedge clk);
         #1;
      end
      if (expWb.size() != 0) begin
         errors++;
         $display("Error at %0t: %0d expected writebacks never came", $time, expWb.size());
      end
      checkFlag("halted", 1'b1, halted);
      checkFlag("err", expErr, err);
      prog.delete();
   endtask

   task automatic finishTest(string name);
      testsRun++;
      if (errors == lastErrors) begin
         $display("Test %s done, no errors", name);
      end else begin
         testsFailed++;
         $display("Test %s done, %0d errors", name, errors - lastErrors);
      end
      lastErrors = errors;
   endtask

`include "procTests.svh"

   initial begin
      rstN        = 1'b0;
      progWr      = '0;
      errors      = 0;
      lastErrors  = 0;
      testsRun    = 0;
      testsFailed = 0;
      @(posedge clk);
      #1;
      arithmeticTest();
      memoryTest();
      controlFlowTest();
      setCompareTest();
      haltTest();
      illegalOpcodeTest();
      $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
